// ==== all.f ====
verilog/tile_pkg.sv
verilog/mem_dev_if.sv
verilog/mem_cmd_dispatch.sv
verilog/mem_resp_merge.sv
verilog/clint_slice.sv
verilog/cfg_slice.sv
verilog/loopback_slice.sv
verilog/tile_mem_top.sv
testbench/tile_mem_assertions.sv
testbench/tb_tile_mem.sv

// ==== testbench/tb_tile_mem.sv ====
// Testbench for the tile memory dispatch
// Clock, reset, directed tests with LFSR data, external memory model
// Watchdog and summary reporting
`timescale 1ns/1ps

module tb_tile_mem
  import tile_pkg::*;
();

  localparam int reset_cycles_c    = 8;
  localparam int num_tests_c       = 6;
  localparam int per_test_cycles_c = 332;
  localparam int watchdog_cycles_c = reset_cycles_c + num_tests_c * per_test_cycles_c;
  localparam int wait_limit_c      = 100;
  localparam logic [63:0] ext_pattern_c = 64'ha5a5_5a5a_c3c3_3c3c;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic cmd_v_i, cmd_ready_o, resp_v_o, resp_ready_i;
  mem_op_e cmd_op_i, resp_op_o, mem_cmd_op_o, mem_resp_op_i;
  logic [paddr_width_c-1:0] cmd_addr_i, resp_addr_o, mem_cmd_addr_o, mem_resp_addr_i;
  logic [data_width_c-1:0] cmd_data_i, resp_data_o, mem_cmd_data_o, mem_resp_data_i;
  logic mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_yumi_o;
  logic timer_irq_o, software_irq_o, external_irq_o;

  logic [15:0] stim_lfsr = 16'd50033;
  logic [15:0] mem_lfsr  = 16'd50033;
  logic        mem_pending;
  logic [1:0]  mem_delay;
  mem_op_e     held_op;
  logic [paddr_width_c-1:0] held_addr;
  int check_errors = 0;
  int test_start   = 0;

  tile_mem_top #(.cfg_regs_p(8)) dut_i (.*);

  always #4 clk_i = ~clk_i;

  // One output bit per step, taps 16, 14, 13, 11
  function automatic logic [63:0] take_bits(input int n, inout logic [15:0] s);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], s[15]};
      s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    end
    return v;
  endfunction

  function automatic logic [paddr_width_c-1:0] local_addr(logic [3:0] dev, logic [19:0] off);
    return {16'h0, dev, off};
  endfunction

  function automatic int total_errors();
    return check_errors + dut_i.asrt_i.fail_count;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      check_errors++;
    end
  endtask

  task automatic issue_cmd(input mem_op_e op, input logic [39:0] addr, input logic [63:0] data);
    int n;
    n = 0;
    @(posedge clk_i);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= op;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!cmd_ready_o && n < wait_limit_c);
    if (!cmd_ready_o)
    begin
      $display("Command at address %h was never accepted", addr);
      check_errors++;
    end
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  // Responses carry the opcode of their command
  task automatic wait_resp(input mem_op_e exp_op, output logic [39:0] addr,
                           output logic [63:0] data);
    int n;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!(resp_v_o && resp_ready_i) && n < wait_limit_c);
    if (!resp_v_o)
    begin
      $display("No response arrived in time");
      check_errors++;
    end
    else
      check_val("resp_op_o", exp_op, resp_op_o);
    addr = resp_addr_o;
    data = resp_data_o;
  endtask

  task automatic end_test(input int num, input string name);
    int errs;
    errs = total_errors() - test_start;
    $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "FAILED", errs);
    test_start = total_errors();
  endtask

  // External memory: accept, wait 0 to 3 cycles, answer address ^ pattern
  always @(posedge clk_i)
  begin : ext_mem_model
    logic [63:0] d;
    if (mem_resp_v_i)
    begin
      if (mem_resp_yumi_o)
      begin
        mem_resp_v_i    <= 1'b0;
        mem_pending     <= 1'b0;
        mem_cmd_ready_i <= 1'b1;
      end
    end
    else if (mem_pending)
    begin
      if (mem_delay == 2'd0)
      begin
        mem_resp_v_i    <= 1'b1;
        mem_resp_op_i   <= held_op;
        mem_resp_addr_i <= held_addr;
        mem_resp_data_i <= {24'h0, held_addr} ^ ext_pattern_c;
      end
      else
        mem_delay <= mem_delay - 2'd1;
    end
    else if (mem_cmd_v_o && mem_cmd_ready_i)
    begin
      d = take_bits(2, mem_lfsr);
      mem_delay       <= d[1:0];
      held_op         <= mem_cmd_op_o;
      held_addr       <= mem_cmd_addr_o;
      mem_pending     <= 1'b1;
      mem_cmd_ready_i <= 1'b0;
    end
  end

  initial
  begin : watchdog
    repeat (watchdog_cycles_c) @(posedge clk_i);
    $display("Run did not finish within %0d cycles, stopping", watchdog_cycles_c);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin : stimulus
    logic [63:0] rnd, data;
    logic [39:0] addr, r_addr;
    logic [63:0] r_data;
    logic [39:0] bp_addr [3];
    mem_op_e     op;
    arst_n_i = 1'b0;
    cmd_v_i = 1'b0;
    cmd_op_i = mem_op_read;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    resp_ready_i = 1'b1;
    mem_cmd_ready_i = 1'b1;
    mem_resp_v_i = 1'b0;
    mem_resp_op_i = mem_op_read;
    mem_resp_addr_i = '0;
    mem_resp_data_i = '0;
    mem_pending = 1'b0;
    mem_delay = 2'd0;
    repeat (reset_cycles_c) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    end_test(1, "reset state");

    rnd = take_bits(3, stim_lfsr);
    addr = local_addr(cfg_dev_c, {rnd[16:0], 3'b000});
    data = take_bits(64, stim_lfsr);
    issue_cmd(mem_op_write, addr, data);
    wait_resp(mem_op_write, r_addr, r_data);
    check_val("resp_data_o", data, r_data);
    issue_cmd(mem_op_read, addr, '0);
    wait_resp(mem_op_read, r_addr, r_data);
    check_val("resp_data_o", data, r_data);
    addr = local_addr(4'd7, 20'h00120);
    issue_cmd(mem_op_read, addr, 64'h1234);
    wait_resp(mem_op_read, r_addr, r_data);
    check_val("resp_addr_o", addr, r_addr);
    check_val("resp_data_o", '0, r_data);
    end_test(2, "cfg and loopback");

    issue_cmd(mem_op_write, local_addr(clint_dev_c, 20'h10), 64'd1);
    wait_resp(mem_op_write, r_addr, r_data);
    check_val("software_irq_o", 1, software_irq_o);
    issue_cmd(mem_op_write, local_addr(clint_dev_c, 20'h18), 64'd1);
    wait_resp(mem_op_write, r_addr, r_data);
    check_val("external_irq_o", 1, external_irq_o);
    issue_cmd(mem_op_write, local_addr(clint_dev_c, 20'h08), 64'd4);
    wait_resp(mem_op_write, r_addr, r_data);
    check_val("timer_irq_o", 1, timer_irq_o);
    repeat (5) @(negedge clk_i);
    check_val("timer_irq_o", 1, timer_irq_o);
    issue_cmd(mem_op_write, local_addr(clint_dev_c, 20'h08), '1);
    wait_resp(mem_op_write, r_addr, r_data);
    check_val("timer_irq_o", 0, timer_irq_o);
    end_test(3, "interrupts");

    for (int i = 0; i < 3; i++)
    begin
      rnd = take_bits(16, stim_lfsr);
      addr = (i == 2) ? local_addr(cache_dev_c, {rnd[16:0], 3'b000})
                      : dram_base_addr_c + {rnd[15:0], 3'b000};
      data = take_bits(64, stim_lfsr);
      op = (i == 1) ? mem_op_read : mem_op_write;
      issue_cmd(op, addr, data);
      wait_resp(op, r_addr, r_data);
      check_val("resp_addr_o", addr, r_addr);
      check_val("resp_data_o", {24'h0, addr} ^ ext_pattern_c, r_data);
    end
    end_test(4, "external memory");

    @(posedge clk_i);
    resp_ready_i <= 1'b0;
    for (int i = 0; i < 3; i++)
    begin
      rnd = take_bits(8, stim_lfsr);
      bp_addr[i] = local_addr(4'd9, {9'h0, rnd[7:0], 3'b000});
      issue_cmd(mem_op_read, bp_addr[i], '0);
    end
    repeat (4) @(negedge clk_i);
    check_val("cmd_ready_o", 0, cmd_ready_o);
    @(posedge clk_i);
    resp_ready_i <= 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      wait_resp(mem_op_read, r_addr, r_data);
      check_val("resp_addr_o", bp_addr[i], r_addr);
    end
    end_test(5, "back-pressure");

    for (int i = 0; i < 3; i++)
    begin
      addr = local_addr(clint_dev_c, i * 8);
      issue_cmd(mem_op_read, addr, '0);
      wait_resp(mem_op_read, r_addr, r_data);
      check_val("resp_addr_o", addr, r_addr);
    end
    end_test(6, "local timing");

    repeat (4) @(posedge clk_i);
    $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
             num_tests_c, check_errors, dut_i.asrt_i.fail_count);
    if (total_errors() == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== testbench/tile_mem_assertions.sv ====
// Concurrent checks bound into the tile memory top level
// Reset state, external pass-through, timer hold, response hold
// Two-cycle local response latency
`timescale 1ns/1ps

module tile_mem_assertions
  import tile_pkg::*;
(
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     cmd_v_i,
  input logic                     cmd_ready_o,
  input mem_op_e                  cmd_op_i,
  input logic [paddr_width_c-1:0] cmd_addr_i,
  input logic [data_width_c-1:0]  cmd_data_i,
  input logic                     resp_v_o,
  input logic                     resp_ready_i,
  input logic [paddr_width_c-1:0] resp_addr_o,
  input logic [data_width_c-1:0]  resp_data_o,
  input logic                     mem_cmd_v_o,
  input mem_op_e                  mem_cmd_op_o,
  input logic [paddr_width_c-1:0] mem_cmd_addr_o,
  input logic [data_width_c-1:0]  mem_cmd_data_o,
  input logic                     mem_resp_yumi_o,
  input logic                     timer_irq_o,
  input logic                     software_irq_o,
  input logic                     external_irq_o
);

  int fail_count = 0;

  logic       accepted;
  logic       is_local;
  logic [3:0] dev;
  logic       local_acc;
  logic       timer_wr;

  assign accepted  = cmd_v_i & cmd_ready_o;
  assign is_local  = (cmd_addr_i < dram_base_addr_c);
  assign dev       = cmd_addr_i[dev_field_lsb_c +: 4];
  assign local_acc = accepted & is_local & (dev != cache_dev_c) & ~resp_v_o & resp_ready_i;
  // Writes to mtime or mtimecmp may clear the timer interrupt
  assign timer_wr  = accepted & is_local & (dev == clint_dev_c) &
                     (cmd_op_i == mem_op_write) & ~cmd_addr_i[4];

  // First edge after reset release
  reset_state_a: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> cmd_ready_o && !resp_v_o && !mem_cmd_v_o && !mem_resp_yumi_o &&
                        !timer_irq_o && !software_irq_o && !external_irq_o)
    else begin $error("outputs not in reset state"); fail_count++; end

  ext_pass_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accepted && !is_local |-> mem_cmd_v_o && mem_cmd_addr_o == cmd_addr_i &&
                              mem_cmd_op_o == cmd_op_i && mem_cmd_data_o == cmd_data_i)
    else begin $error("external command changed on the way out"); fail_count++; end

  timer_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    timer_irq_o && !$past(timer_wr) |=> timer_irq_o)
    else begin $error("timer interrupt dropped without a compare write"); fail_count++; end

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_addr_o) && $stable(resp_data_o))
    else begin $error("response changed while stalled"); fail_count++; end

  // Accept at N, response visible after edge N+2
  local_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    local_acc |-> ##2 !resp_v_o ##1 resp_v_o)
    else begin $error("local response latency is not two cycles"); fail_count++; end

endmodule

bind tile_mem_top tile_mem_assertions asrt_i (.*);

// ==== verilog/tile_mem_top.sv ====
// Tile memory dispatch top level
// Command decode, four targets and response merge
// External memory target is mapped onto plain ports
`timescale 1ns/1ps

module tile_mem_top
  import tile_pkg::*;
#(
  parameter int cfg_regs_p = 8
)
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  input  mem_op_e                  cmd_op_i,
  input  logic [paddr_width_c-1:0] cmd_addr_i,
  input  logic [data_width_c-1:0]  cmd_data_i,

  output logic                     resp_v_o,
  input  logic                     resp_ready_i,
  output mem_op_e                  resp_op_o,
  output logic [paddr_width_c-1:0] resp_addr_o,
  output logic [data_width_c-1:0]  resp_data_o,

  output logic                     mem_cmd_v_o,
  input  logic                     mem_cmd_ready_i,
  output mem_op_e                  mem_cmd_op_o,
  output logic [paddr_width_c-1:0] mem_cmd_addr_o,
  output logic [data_width_c-1:0]  mem_cmd_data_o,

  input  logic                     mem_resp_v_i,
  output logic                     mem_resp_yumi_o,
  input  mem_op_e                  mem_resp_op_i,
  input  logic [paddr_width_c-1:0] mem_resp_addr_i,
  input  logic [data_width_c-1:0]  mem_resp_data_i,

  output logic                     timer_irq_o,
  output logic                     software_irq_o,
  output logic                     external_irq_o
);

  mem_msg_s cmd_li;
  mem_msg_s resp_lo;
  mem_msg_s ext_resp_li;

  mem_dev_if tgt_if [num_targets_c] ();

  assign cmd_li.op       = cmd_op_i;
  assign cmd_li.addr.raw = cmd_addr_i;
  assign cmd_li.data     = cmd_data_i;

  assign resp_op_o   = resp_lo.op;
  assign resp_addr_o = resp_lo.addr.raw;
  assign resp_data_o = resp_lo.data;

  mem_cmd_dispatch dispatch_i (
    .cmd_v_i    (cmd_v_i),
    .cmd_i      (cmd_li),
    .cmd_ready_o(cmd_ready_o),
    .tgt        (tgt_if)
  );

  mem_resp_merge merge_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .tgt         (tgt_if),
    .resp_v_o    (resp_v_o),
    .resp_ready_i(resp_ready_i),
    .resp_o      (resp_lo)
  );

  cfg_slice #(
    .cfg_regs_p(cfg_regs_p)
  ) cfg_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .bus     (tgt_if[tgt_cfg])
  );

  clint_slice clint_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .bus           (tgt_if[tgt_clint]),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o),
    .external_irq_o(external_irq_o)
  );

  loopback_slice loopback_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .bus     (tgt_if[tgt_loopback])
  );

  // Cache target goes straight out to external memory
  assign mem_cmd_v_o    = tgt_if[tgt_cache].cmd_v;
  assign mem_cmd_op_o   = tgt_if[tgt_cache].cmd.op;
  assign mem_cmd_addr_o = tgt_if[tgt_cache].cmd.addr.raw;
  assign mem_cmd_data_o = tgt_if[tgt_cache].cmd.data;
  assign tgt_if[tgt_cache].cmd_ready = mem_cmd_ready_i;

  assign ext_resp_li.op       = mem_resp_op_i;
  assign ext_resp_li.addr.raw = mem_resp_addr_i;
  assign ext_resp_li.data     = mem_resp_data_i;

  assign tgt_if[tgt_cache].resp   = ext_resp_li;
  assign tgt_if[tgt_cache].resp_v = mem_resp_v_i;
  assign mem_resp_yumi_o          = tgt_if[tgt_cache].resp_yumi;

endmodule

// ==== verilog/loopback_slice.sv ====
// Loopback device for unmapped local addresses
// Answers every command with its opcode and address and zero data
`timescale 1ns/1ps

module loopback_slice
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_dev_if.device bus
);

  logic      cmd_v_r;
  logic      resp_v_r;
  mem_op_e   op_r;
  mem_addr_u addr_r;
  logic      accept;

  assign bus.cmd_ready = ~cmd_v_r & ~resp_v_r;
  assign accept        = bus.cmd_v & bus.cmd_ready;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cmd_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      cmd_v_r <= accept;
      if (cmd_v_r)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;
    end
  end

  // Fields only change on accept, so they hold until yumi
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_r   <= bus.cmd.op;
      addr_r <= bus.cmd.addr;
    end
  end

  assign bus.resp   = '{op: op_r, addr: addr_r, data: '0};
  assign bus.resp_v = resp_v_r;

endmodule

// ==== verilog/cfg_slice.sv ====
// Configuration register slice
// cfg_regs_p words, indexed by offset in 8-byte steps
// Writes store and echo the data, reads return the stored word
`timescale 1ns/1ps

module cfg_slice
  import tile_pkg::*;
#(
  parameter int cfg_regs_p = 8
)
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_dev_if.device bus
);

  localparam int idx_width_lp = $clog2(cfg_regs_p);

  logic                    cmd_v_r;
  mem_msg_s                cmd_r;
  logic                    resp_v_r;
  mem_msg_s                resp_r;
  logic [data_width_c-1:0] regs_r [cfg_regs_p];
  logic [idx_width_lp-1:0] idx;
  logic                    accept;
  logic                    wr_en;

  assign bus.cmd_ready = ~cmd_v_r & ~resp_v_r;
  assign accept        = bus.cmd_v & bus.cmd_ready;

  // Word index wraps on the register count
  assign idx   = cmd_r.addr.loc.offset[3 +: idx_width_lp];
  assign wr_en = cmd_v_r & (cmd_r.op == mem_op_write);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cmd_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
      for (int i = 0; i < cfg_regs_p; i++)
        regs_r[i] <= '0;
    end
    else
    begin
      cmd_v_r <= accept;
      if (cmd_v_r)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;
      if (wr_en)
        regs_r[idx] <= cmd_r.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      cmd_r <= bus.cmd;
    if (cmd_v_r)
    begin
      resp_r.op   <= cmd_r.op;
      resp_r.addr <= cmd_r.addr;
      resp_r.data <= wr_en ? cmd_r.data : regs_r[idx];
    end
  end

  assign bus.resp   = resp_r;
  assign bus.resp_v = resp_v_r;

endmodule

// ==== verilog/clint_slice.sv ====
// Core-local interrupter
// mtime, mtimecmp, msip and meip registers behind one command port
// Timer, software and external interrupt outputs
`timescale 1ns/1ps

module clint_slice
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_dev_if.device bus,
  output logic      timer_irq_o,
  output logic      software_irq_o,
  output logic      external_irq_o
);

  logic                    cmd_v_r;
  mem_msg_s                cmd_r;
  logic                    resp_v_r;
  mem_msg_s                resp_r;
  logic [data_width_c-1:0] mtime_r;
  logic [data_width_c-1:0] mtimecmp_r;
  logic                    msip_r;
  logic                    meip_r;
  logic                    accept;
  logic                    wr_en;
  logic [1:0]              reg_sel;
  logic [data_width_c-1:0] rd_data;

  assign bus.cmd_ready = ~cmd_v_r & ~resp_v_r;
  assign accept        = bus.cmd_v & bus.cmd_ready;

  // Offsets 0x0, 0x8, 0x10, 0x18
  assign reg_sel = cmd_r.addr.loc.offset[4:3];
  assign wr_en   = cmd_v_r & (cmd_r.op == mem_op_write);

  always_comb
  begin
    case (reg_sel)
      2'd0:    rd_data = mtime_r;
      2'd1:    rd_data = mtimecmp_r;
      2'd2:    rd_data = {{(data_width_c-1){1'b0}}, msip_r};
      default: rd_data = {{(data_width_c-1){1'b0}}, meip_r};
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cmd_v_r    <= 1'b0;
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      meip_r     <= 1'b0;
    end
    else
    begin
      cmd_v_r <= accept;
      if (cmd_v_r)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;
      // Free-running unless software loads it
      if (wr_en && reg_sel == 2'd0)
        mtime_r <= cmd_r.data;
      else
        mtime_r <= mtime_r + 1'b1;
      if (wr_en && reg_sel == 2'd1)
        mtimecmp_r <= cmd_r.data;
      if (wr_en && reg_sel == 2'd2)
        msip_r <= cmd_r.data[0];
      if (wr_en && reg_sel == 2'd3)
        meip_r <= cmd_r.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      cmd_r <= bus.cmd;
    if (cmd_v_r)
    begin
      resp_r.op   <= cmd_r.op;
      resp_r.addr <= cmd_r.addr;
      resp_r.data <= wr_en ? cmd_r.data : rd_data;
    end
  end

  assign bus.resp   = resp_r;
  assign bus.resp_v = resp_v_r;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;
  assign external_irq_o = meip_r;

endmodule

// ==== verilog/mem_resp_merge.sv ====
// Response merge for the four targets
// Fixed-priority arbiter, lowest index first, grant is the yumi
// One-hot response select and two-entry response FIFO
`timescale 1ns/1ps

module mem_resp_merge
  import tile_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  mem_dev_if.dispatch tgt [num_targets_c],
  output logic        resp_v_o,
  input  logic        resp_ready_i,
  output mem_msg_s    resp_o
);

  localparam int msg_width_lp = $bits(mem_msg_s);

  logic [num_targets_c-1:0] req;
  logic [num_targets_c-1:0] grant;
  logic [msg_width_lp-1:0]  resp_bits [num_targets_c];
  logic [msg_width_lp-1:0]  sel_bits;

  logic       fifo_ready;
  logic       push;
  logic       pop;
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  mem_msg_s   fifo_mem [2];

  for (genvar i = 0; i < num_targets_c; i++)
  begin : g_tgt
    assign req[i]         = tgt[i].resp_v;
    assign resp_bits[i]   = tgt[i].resp;
    assign tgt[i].resp_yumi = grant[i];
  end

  assign fifo_ready = (count != 2'd2);

  // Isolate the lowest set request bit
  assign grant = fifo_ready ? (req & (~req + 1'b1)) : '0;

  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < num_targets_c; i++)
    begin
      if (grant[i])
        sel_bits = sel_bits | resp_bits[i];
    end
  end

  assign push = |grant;
  assign pop  = resp_v_o & resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      wr_ptr <= wr_ptr ^ push;
      rd_ptr <= rd_ptr ^ pop;
      count  <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      fifo_mem[wr_ptr] <= mem_msg_s'(sel_bits);
  end

  assign resp_v_o = (count != 2'd0);
  assign resp_o   = fifo_mem[rd_ptr];

endmodule

// ==== verilog/mem_cmd_dispatch.sv ====
// Command dispatch for the tile memory map
// Address decode into cache, cfg, clint or loopback target
// Valid steering and ready combining over all targets
`timescale 1ns/1ps

module mem_cmd_dispatch
  import tile_pkg::*;
(
  input  logic        cmd_v_i,
  input  mem_msg_s    cmd_i,
  output logic        cmd_ready_o,
  mem_dev_if.dispatch tgt [num_targets_c]
);

  mem_addr_u                addr;
  logic                     is_local;
  logic [num_targets_c-1:0] sel;
  logic [num_targets_c-1:0] ready;

  assign addr     = cmd_i.addr;
  assign is_local = (addr.raw < dram_base_addr_c);

  // Exactly one target per command
  always_comb
  begin
    sel = '0;
    if (!is_local || addr.loc.dev == cache_dev_c)
      sel[tgt_cache] = 1'b1;
    else if (addr.loc.dev == cfg_dev_c)
      sel[tgt_cfg] = 1'b1;
    else if (addr.loc.dev == clint_dev_c)
      sel[tgt_clint] = 1'b1;
    else
      sel[tgt_loopback] = 1'b1;
  end

  for (genvar i = 0; i < num_targets_c; i++)
  begin : g_tgt
    assign tgt[i].cmd = cmd_i;
    // Only hand over when every target can take it
    assign tgt[i].cmd_v = cmd_v_i & sel[i] & cmd_ready_o;
    assign ready[i]     = tgt[i].cmd_ready;
  end

  assign cmd_ready_o = &ready;

endmodule

// ==== verilog/mem_dev_if.sv ====
// Command/response channel between dispatch logic and one device
// Commands use valid/ready, responses use valid/yumi
`timescale 1ns/1ps

interface mem_dev_if
  import tile_pkg::*;
();

  mem_msg_s cmd;
  logic     cmd_v;
  logic     cmd_ready;

  mem_msg_s resp;
  logic     resp_v;
  logic     resp_yumi;

  modport dispatch (
    output cmd,
    output cmd_v,
    input  cmd_ready,
    input  resp,
    input  resp_v,
    output resp_yumi
  );

  modport device (
    input  cmd,
    input  cmd_v,
    output cmd_ready,
    output resp,
    output resp_v,
    input  resp_yumi
  );

endinterface

// ==== verilog/tile_pkg.sv ====
// Shared definitions for the tile memory dispatch
// Address and data widths, memory map and local device numbers
// Opcode enum, address union, message struct and target index
package tile_pkg;

  localparam int paddr_width_c   = 40;
  localparam int data_width_c    = 64;
  localparam int dev_field_lsb_c = 20;
  localparam int num_targets_c   = 4;

  // Everything below this address is tile-local
  localparam logic [paddr_width_c-1:0] dram_base_addr_c = 40'h00_8000_0000;

  localparam logic [3:0] clint_dev_c = 4'd1;
  localparam logic [3:0] cfg_dev_c   = 4'd2;
  localparam logic [3:0] cache_dev_c = 4'd3;

  typedef enum logic [1:0] {
    mem_op_read  = 2'b00,
    mem_op_write = 2'b01
  } mem_op_e;

  // Raw view for the DRAM compare, local view for device decode
  typedef union packed {
    logic [paddr_width_c-1:0] raw;
    struct packed {
      logic [paddr_width_c-dev_field_lsb_c-5:0] upper;
      logic [3:0]                               dev;
      logic [dev_field_lsb_c-1:0]               offset;
    } loc;
  } mem_addr_u;

  typedef struct packed {
    mem_op_e                 op;
    mem_addr_u               addr;
    logic [data_width_c-1:0] data;
  } mem_msg_s;

  // Index is also the response priority, lowest first
  typedef enum logic [1:0] {
    tgt_cache    = 2'd0,
    tgt_cfg      = 2'd1,
    tgt_clint    = 2'd2,
    tgt_loopback = 2'd3
  } target_e;

endpackage
